//--- source/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  func_t;
	typedef logic [2:0]  aluOp_t;
	typedef logic [3:0]  aluFunc_t;

	localparam opcode_t opR    = 6'h03; // R-type, lwn, swn, jr
	localparam opcode_t opJ    = 6'h02;
	localparam opcode_t opJal  = 6'h07;
	localparam opcode_t opAddi = 6'h09;
	localparam opcode_t opAndi = 6'h0c;
	localparam opcode_t opOri  = 6'h0e;
	localparam opcode_t opBeq  = 6'h05;
	localparam opcode_t opBne  = 6'h04;
	localparam opcode_t opLbu  = 6'h22;
	localparam opcode_t opLui  = 6'h0f;
	localparam opcode_t opLw   = 6'h12;
	localparam opcode_t opSb   = 6'h28;
	localparam opcode_t opSw   = 6'h2b;

	localparam func_t fnJr   = 6'h08;
	localparam func_t fnLwn  = 6'h21; // load from rs + rd
	localparam func_t fnSwn  = 6'h13; // store rt to rs + rd
	localparam func_t fnAdd  = 6'h20;
	localparam func_t fnSub  = 6'h22;
	localparam func_t fnAnd  = 6'h24;
	localparam func_t fnOr   = 6'h25;
	localparam func_t fnNor  = 6'h27;
	localparam func_t fnSlt  = 6'h2a;
	localparam func_t fnSltu = 6'h2b;
	localparam func_t fnSll  = 6'h00;
	localparam func_t fnSrl  = 6'h02;

	localparam aluOp_t aluByFunc = 3'd0;
	localparam aluOp_t aluAdd    = 3'd1;
	localparam aluOp_t aluSub    = 3'd2;
	localparam aluOp_t aluAnd    = 3'd3;
	localparam aluOp_t aluOr     = 3'd4;

	// resolved ALU operations
	localparam aluFunc_t aluFnAdd  = 4'd0;
	localparam aluFunc_t aluFnSub  = 4'd1;
	localparam aluFunc_t aluFnAnd  = 4'd2;
	localparam aluFunc_t aluFnOr   = 4'd3;
	localparam aluFunc_t aluFnNor  = 4'd4;
	localparam aluFunc_t aluFnSlt  = 4'd5;
	localparam aluFunc_t aluFnSltu = 4'd6;
	localparam aluFunc_t aluFnSll  = 4'd7;
	localparam aluFunc_t aluFnSrl  = 4'd8;

	localparam logic [1:0] jumpBranch   = 2'd0;
	localparam logic [1:0] jumpTarget   = 2'd1;
	localparam logic [1:0] jumpRegister = 2'd2;
	localparam logic [1:0] jumpNone     = 2'd3;

	localparam logic [1:0] destRt = 2'd0;
	localparam logic [1:0] destRd = 2'd1;
	localparam logic [1:0] destRa = 2'd2;

	localparam logic [1:0] srcAlu = 2'd0;
	localparam logic [1:0] srcMem = 2'd1;
	localparam logic [1:0] srcImm = 2'd2;

	// operand B select
	localparam logic [1:0] srcBReg  = 2'd0;
	localparam logic [1:0] srcBImm  = 2'd1;
	localparam logic [1:0] srcBLink = 2'd2;

	localparam logic [1:0] memNone  = 2'd0;
	localparam logic [1:0] memWrite = 2'd1;
	localparam logic [1:0] memRead  = 2'd2;

	localparam logic [1:0] branchNone = 2'd0;
	localparam logic [1:0] branchEq   = 2'd1;
	localparam logic [1:0] branchNe   = 2'd2;

endpackage

//--- source/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input  cpuPkg::opcode_t opcode,
	input  cpuPkg::func_t   func,
	output cpuPkg::aluOp_t  aluOp,
	output logic            regWrite,
	output logic [1:0]      regDest,
	output logic [1:0]      regSrc,
	output logic            aluSrc1,
	output logic [1:0]      aluSrc2,
	output logic [1:0]      jump,
	output logic [1:0]      branchType,
	output logic [1:0]      memAccess,
	output logic            wordByte,
	output logic            zeroExtend,
	output logic            readRegTwo,
	output logic            memData
);
	import cpuPkg::*;

	always_comb begin
		// defaults describe a no-op
		aluOp      = aluAdd;
		regWrite   = 1'b0;
		regDest    = destRt;
		regSrc     = srcAlu;
		aluSrc1    = 1'b1; // rs
		aluSrc2    = srcBReg;
		jump       = jumpNone;
		branchType = branchNone;
		memAccess  = memNone;
		wordByte   = 1'b0; // word
		zeroExtend = 1'b0;
		readRegTwo = 1'b0; // rt
		memData    = 1'b0;

		case (opcode)
			opR: begin
				aluOp = aluByFunc;
				case (func)
					fnJr: begin
						jump = jumpRegister;
					end
					fnLwn: begin
						regWrite   = 1'b1;
						regDest    = destRt;
						regSrc     = srcMem;
						memAccess  = memRead;
						readRegTwo = 1'b1; // rd as offset
					end
					fnSwn: begin
						memAccess  = memWrite;
						readRegTwo = 1'b1;
						memData    = 1'b1; // store data from rt port
					end
					default: begin
						regWrite = 1'b1; // plain ALU ops
						regDest  = destRd;
					end
				endcase
			end
			opJ: begin
				jump = jumpTarget;
			end
			opJal: begin
				jump     = jumpTarget;
				regWrite = 1'b1;
				regDest  = destRa;
				aluSrc1  = 1'b0; // zero + link
				aluSrc2  = srcBLink;
			end
			opAddi: begin
				regWrite = 1'b1;
				aluSrc2  = srcBImm;
			end
			opAndi: begin
				aluOp      = aluAnd;
				regWrite   = 1'b1;
				aluSrc2    = srcBImm;
				zeroExtend = 1'b1;
			end
			opOri: begin
				aluOp      = aluOr;
				regWrite   = 1'b1;
				aluSrc2    = srcBImm;
				zeroExtend = 1'b1;
			end
			opBeq: begin
				aluOp      = aluSub; // zero flag on equal
				jump       = jumpBranch;
				branchType = branchEq;
			end
			opBne: begin
				aluOp      = aluSub;
				jump       = jumpBranch;
				branchType = branchNe;
			end
			opLbu: begin
				regWrite  = 1'b1;
				regSrc    = srcMem;
				aluSrc2   = srcBImm;
				memAccess = memRead;
				wordByte  = 1'b1;
			end
			opLw: begin
				regWrite  = 1'b1;
				regSrc    = srcMem;
				aluSrc2   = srcBImm;
				memAccess = memRead;
			end
			opLui: begin
				regWrite = 1'b1;
				regSrc   = srcImm; // upper immediate, no ALU
			end
			opSb: begin
				aluSrc2   = srcBImm;
				memAccess = memWrite;
				wordByte  = 1'b1;
			end
			opSw: begin
				aluSrc2   = srcBImm;
				memAccess = memWrite;
			end
			default: begin
				regWrite = 1'b0; // unknown opcode, no-op
			end
		endcase
	end

endmodule

//--- source/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
	input  cpuPkg::aluOp_t aluOp,
	input  cpuPkg::func_t  func,
	input  logic [4:0]     shamt,
	input  cpuPkg::word_t  operandA,
	input  cpuPkg::word_t  operandB,
	output cpuPkg::word_t  result,
	output logic           zero
);
	import cpuPkg::*;

	aluFunc_t operation;

	// class code plus function field down to one operation
	always_comb begin
		case (aluOp)
			aluSub: operation = aluFnSub;
			aluAnd: operation = aluFnAnd;
			aluOr:  operation = aluFnOr;
			aluByFunc: begin
				case (func)
					fnSub:   operation = aluFnSub;
					fnAnd:   operation = aluFnAnd;
					fnOr:    operation = aluFnOr;
					fnNor:   operation = aluFnNor;
					fnSlt:   operation = aluFnSlt;
					fnSltu:  operation = aluFnSltu;
					fnSll:   operation = aluFnSll;
					fnSrl:   operation = aluFnSrl;
					default: operation = aluFnAdd; // add, lwn, swn
				endcase
			end
			default: operation = aluFnAdd;
		endcase
	end

	always_comb begin
		case (operation)
			aluFnSub:  result = operandA - operandB;
			aluFnAnd:  result = operandA & operandB;
			aluFnOr:   result = operandA | operandB;
			aluFnNor:  result = ~(operandA | operandB);
			aluFnSlt:  result = {31'b0, $signed(operandA) < $signed(operandB)};
			aluFnSltu: result = {31'b0, operandA < operandB};
			aluFnSll:  result = operandB << shamt;
			aluFnSrl:  result = operandB >> shamt; // logical
			default:   result = operandA + operandB;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- source/registerFile.sv
`timescale 1ns/100ps

module registerFile (
	input  logic             clk,
	input  logic             reset,
	input  cpuPkg::regAddr_t readAddrA,
	input  cpuPkg::regAddr_t readAddrB,
	input  cpuPkg::regAddr_t readAddrC,
	input  logic             writeEnable,
	input  cpuPkg::regAddr_t writeAddr,
	input  cpuPkg::word_t    writeData,
	output cpuPkg::word_t    readDataA,
	output cpuPkg::word_t    readDataB,
	output cpuPkg::word_t    readDataC
);
	import cpuPkg::*;

	word_t regs [1:31]; // no storage behind register 0

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
	assign readDataC = (readAddrC == '0) ? '0 : regs[readAddrC];

endmodule

//--- source/loadStoreUnit.sv
`timescale 1ns/100ps

module loadStoreUnit (
	input  logic [1:0]    memAccess,
	input  logic          wordByte,
	input  cpuPkg::word_t address,
	input  cpuPkg::word_t storeData,
	input  cpuPkg::word_t dataReadData,
	output cpuPkg::word_t dataAddr,
	output cpuPkg::word_t dataWriteData,
	output cpuPkg::word_t loadData,
	output logic [3:0]    dataByteEnable,
	output logic          dataWrite,
	output logic          dataRead
);
	import cpuPkg::*;

	logic [1:0] lane;
	logic [7:0] loadByte;

	assign lane     = address[1:0];
	assign dataAddr = address; // memory drops bits 1:0 itself

	assign dataWrite = (memAccess == memWrite);
	assign dataRead  = (memAccess == memRead);

	// byte stores replicate onto every lane
	assign dataWriteData = wordByte ? {4{storeData[7:0]}} : storeData;

	always_comb begin
		if (!dataWrite) begin
			dataByteEnable = 4'b0000;
		end else if (wordByte) begin
			dataByteEnable = 4'b0001 << lane;
		end else begin
			dataByteEnable = 4'b1111;
		end
	end

	assign loadByte = dataReadData[8*lane +: 8]; // little-endian lanes
	assign loadData = wordByte ? {24'b0, loadByte} : dataReadData;

endmodule

//--- source/nextPcUnit.sv
`timescale 1ns/100ps

module nextPcUnit #(
	parameter cpuPkg::word_t resetAddress = '0
) (
	input  logic          clk,
	input  logic          reset,
	input  logic [1:0]    jump,
	input  logic [1:0]    branchType,
	input  logic          zero,
	input  logic [25:0]   jumpIndex,
	input  cpuPkg::word_t branchOffset,
	input  cpuPkg::word_t registerTarget,
	output cpuPkg::word_t pc,
	output cpuPkg::word_t pcPlusEight
);
	import cpuPkg::*;

	word_t pcPlusFour;
	word_t redirectTarget;
	word_t pendingTarget;
	logic  pendingValid;
	logic  redirect;
	logic  branchTaken;

	assign pcPlusFour  = pc + 32'd4;
	assign pcPlusEight = pc + 32'd8; // link skips the delay slot

	assign branchTaken = (branchType == branchEq && zero) || (branchType == branchNe && !zero);

	always_comb begin
		case (jump)
			jumpTarget:   redirectTarget = {pcPlusFour[31:28], jumpIndex, 2'b00};
			jumpRegister: redirectTarget = registerTarget;
			default:      redirectTarget = pcPlusFour + (branchOffset << 2);
		endcase
	end

	assign redirect = (jump == jumpTarget) || (jump == jumpRegister) ||
		(jump == jumpBranch && branchTaken);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc           <= resetAddress;
			pendingValid <= 1'b0;
		end else begin
			pc           <= pendingValid ? pendingTarget : pcPlusFour; // delay slot first
			pendingValid <= redirect;
		end
	end

	always_ff @(posedge clk) begin
		pendingTarget <= redirectTarget;
	end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/100ps

module cpuCore #(
	parameter cpuPkg::word_t resetAddress = '0
) (
	input  logic          clk,
	input  logic          reset,
	input  cpuPkg::word_t instrData,
	input  cpuPkg::word_t dataReadData,
	output cpuPkg::word_t instrAddr,
	output cpuPkg::word_t dataAddr,
	output cpuPkg::word_t dataWriteData,
	output logic [3:0]    dataByteEnable,
	output logic          dataWrite,
	output logic          dataRead
);
	import cpuPkg::*;

	opcode_t    opcode;
	func_t      func;
	regAddr_t   rs, rt, rd, writeAddr;
	logic [4:0] shamt;
	logic [15:0] imm;
	word_t      immSigned, immExtended, operandA, operandB, writeData;
	word_t      readDataA, readDataB, readDataC, storeData;
	word_t      aluResult, loadData, pcPlusEight;
	aluOp_t     aluOp;
	logic [1:0] regDest, regSrc, aluSrc2, jump, branchType, memAccess;
	logic       regWrite, aluSrc1, wordByte, zeroExtend, readRegTwo, memData;
	logic       zero, lsuWrite, lsuRead;

	assign opcode = instrData[31:26];
	assign rs     = instrData[25:21];
	assign rt     = instrData[20:16];
	assign rd     = instrData[15:11];
	assign shamt  = instrData[10:6];
	assign func   = instrData[5:0];
	assign imm    = instrData[15:0];

	assign immSigned   = {{16{imm[15]}}, imm};
	assign immExtended = zeroExtend ? {16'b0, imm} : immSigned;

	controlUnit control_i (.opcode, .func, .aluOp, .regWrite, .regDest, .regSrc, .aluSrc1,
		.aluSrc2, .jump, .branchType, .memAccess, .wordByte, .zeroExtend, .readRegTwo, .memData);

	registerFile regFile_i (.clk, .reset, .readAddrA(rs), .readAddrB(readRegTwo ? rd : rt),
		.readAddrC(rt), .writeEnable(regWrite), .writeAddr, .writeData,
		.readDataA, .readDataB, .readDataC);

	assign operandA  = aluSrc1 ? readDataA : '0;
	assign operandB  = (aluSrc2 == srcBImm) ? immExtended :
		(aluSrc2 == srcBLink) ? pcPlusEight : readDataB;
	assign storeData = memData ? readDataC : readDataB; // swn stores rt

	aluUnit alu_i (.aluOp, .func, .shamt, .operandA, .operandB, .result(aluResult), .zero);

	loadStoreUnit lsu_i (.memAccess, .wordByte, .address(aluResult), .storeData, .dataReadData,
		.dataAddr, .dataWriteData, .loadData, .dataByteEnable, .dataWrite(lsuWrite),
		.dataRead(lsuRead));

	nextPcUnit #(.resetAddress(resetAddress)) nextPc_i (.clk, .reset, .jump, .branchType, .zero,
		.jumpIndex(instrData[25:0]), .branchOffset(immSigned), .registerTarget(readDataA),
		.pc(instrAddr), .pcPlusEight);

	assign writeAddr = (regDest == destRd) ? rd : (regDest == destRa) ? 5'd31 : rt;
	assign writeData = (regSrc == srcMem) ? loadData :
		(regSrc == srcImm) ? {imm, 16'b0} : aluResult; // lui

	assign dataWrite = lsuWrite && !reset; // no strobes while in reset
	assign dataRead  = lsuRead && !reset;

endmodule

//--- testbench/cpuCore_asserts.sv
`timescale 1ns/100ps

module cpuCore_asserts #(
	parameter cpuPkg::word_t resetAddress = '0
) (
	input logic          clk,
	input logic          reset,
	input cpuPkg::word_t instrAddr,
	input logic [3:0]    dataByteEnable,
	input logic          dataWrite,
	input logic          dataRead
);

	strobesExclusive: assert property (@(posedge clk) !(dataWrite && dataRead))
		else $error("dataWrite and dataRead high together");

	quietInReset: assert property (@(posedge clk) reset |-> !dataWrite && !dataRead)
		else $error("data strobe active during reset");

	resetFetch: assert property (@(posedge clk) reset |=> instrAddr == resetAddress)
		else $error("instrAddr differs from resetAddress after a reset cycle");

	// word store or a single byte lane
	enableShape: assert property (@(posedge clk)
		dataWrite |-> (dataByteEnable == 4'hf) || $onehot(dataByteEnable))
		else $error("illegal byte enable pattern %b", dataByteEnable);

	fetchAligned: assert property (@(posedge clk) !reset |-> instrAddr[1:0] == 2'b00)
		else $error("instrAddr not word aligned");

endmodule

bind cpuCore cpuCore_asserts #(.resetAddress(resetAddress)) asserts_i (
	.clk(clk),
	.reset(reset),
	.instrAddr(instrAddr),
	.dataByteEnable(dataByteEnable),
	.dataWrite(dataWrite),
	.dataRead(dataRead)
);

//--- testbench/tb_cpuCore.sv
`timescale 1ns/100ps

module tb_cpuCore;
	import cpuPkg::*;

	localparam word_t resetAddr = 32'h0000_0040;
	localparam word_t endAddr   = 32'h0000_03fc; // every program ends with a store here
	localparam word_t endMarker = 32'h600d_c0de;
	localparam word_t flagValue = 32'h0000_0077; // written by control flow markers

	logic       clk;
	logic       reset;
	word_t      instrData, dataReadData, instrAddr, dataAddr, dataWriteData;
	logic [3:0] dataByteEnable;
	logic       dataWrite, dataRead;
	word_t      instrMem [0:255];
	word_t      dataMem [0:255];
	integer     seed;
	int         slot; // next free instruction word

	cpuCore #(.resetAddress(resetAddr)) dut_i (.clk, .reset, .instrData, .dataReadData,
		.instrAddr, .dataAddr, .dataWriteData, .dataByteEnable, .dataWrite, .dataRead);

	assign instrData    = instrMem[instrAddr[9:2]];
	assign dataReadData = dataRead ? dataMem[dataAddr[9:2]] // bits 1:0 ignored
		: ~dataMem[dataAddr[9:2]]; // wrong data unless dataRead

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (dataWrite) begin // lane 0 is bits 7:0
			if (dataByteEnable[0]) dataMem[dataAddr[9:2]][7:0] <= dataWriteData[7:0];
			if (dataByteEnable[1]) dataMem[dataAddr[9:2]][15:8] <= dataWriteData[15:8];
			if (dataByteEnable[2]) dataMem[dataAddr[9:2]][23:16] <= dataWriteData[23:16];
			if (dataByteEnable[3]) dataMem[dataAddr[9:2]][31:24] <= dataWriteData[31:24];
		end
	end

	// sb only targets 0x120..0x12f, all other stores are words
	always @(negedge clk) begin
		if (!reset && dataWrite) begin
			if (dataAddr >= 32'h120 && dataAddr < 32'h130) begin
				checkValue("dataByteEnable", {28'h0, dataByteEnable},
					{28'h0, 4'b0001 << dataAddr[1:0]});
			end else begin
				checkValue("dataByteEnable", {28'h0, dataByteEnable}, 32'h0000_000f);
			end
		end
	end

	task automatic stopOnFailure(string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			stopOnFailure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
				name, actual, expected));
		end
	endtask

	function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd,
		logic [4:0] shamt, func_t fn);
		return {opR, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(opcode_t op, word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic word_t slotAddr(int idx); // address of program word idx
		return resetAddr + word_t'(4 * idx);
	endfunction

	function automatic word_t fillPattern(word_t addr);
		return 32'h5a5a_0000 ^ (addr * 32'h0001_0001);
	endfunction

	function automatic word_t memAt(word_t addr);
		return dataMem[addr[9:2]];
	endfunction

	// reference ALU model
	function automatic word_t expectedAlu(func_t fn, word_t a, word_t b, logic [4:0] sh);
		case (fn)
			fnSub:   return a - b;
			fnAnd:   return a & b;
			fnOr:    return a | b;
			fnNor:   return ~(a | b);
			fnSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			fnSltu:  return (a < b) ? 32'd1 : 32'd0;
			fnSll:   return b << sh;
			fnSrl:   return b >> sh;
			default: return a + b;
		endcase
	endfunction

	task automatic clearMemories();
		for (int i = 0; i < 256; i++) begin
			instrMem[i] = '0; // opcode 0 decodes as a no-op
			dataMem[i]  = fillPattern(word_t'(i * 4));
		end
		slot = int'(resetAddr[9:2]);
	endtask

	task automatic placeInstr(word_t instr);
		instrMem[slot] = instr;
		slot++;
	endtask

	task automatic storeFlagAt(logic [15:0] offset);
		placeInstr(iType(opSw, 5'd0, 5'd20, offset));
	endtask

	task automatic appendEndMarker();
		placeInstr(iType(opLui, 5'd0, 5'd30, endMarker[31:16]));
		placeInstr(iType(opOri, 5'd30, 5'd30, endMarker[15:0]));
		placeInstr(iType(opSw, 5'd0, 5'd30, endAddr[15:0]));
	endtask

	// reset is high on entry and is raised again once the end marker lands
	task automatic runProgram();
		int cycles;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i == 15) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			checkValue("instrAddr", instrAddr, resetAddr); // last pass is the first fetch
			if (reset) begin
				checkValue("dataWrite,dataRead", {30'h0, dataWrite, dataRead}, 32'h0);
			end
		end
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 500) begin
				stopOnFailure("program never stored its end marker within 500 cycles");
			end
		end while (!(dataWrite && dataAddr == endAddr));
		checkValue("end marker", dataWriteData, endMarker);
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
	endtask

	task automatic rTypeArithmetic();
		func_t      fns [9];
		word_t      a, b, r;
		logic [4:0] sh;
		fns = '{fnAdd, fnSub, fnAnd, fnOr, fnNor, fnSlt, fnSltu, fnSll, fnSrl};
		a = $random(seed);
		b = $random(seed);
		r = $random(seed);
		sh = r[4:0];
		clearMemories();
		dataMem[0] = a;
		dataMem[1] = b;
		placeInstr(iType(opLw, 5'd0, 5'd1, 16'h0000));
		placeInstr(iType(opLw, 5'd0, 5'd2, 16'h0004));
		for (int k = 0; k < 9; k++) begin
			placeInstr(rType(5'd1, 5'd2, regAddr_t'(3 + k), sh, fns[k]));
			placeInstr(iType(opSw, 5'd0, regAddr_t'(3 + k), 16'(32'h140 + 4 * k)));
		end
		appendEndMarker();
		runProgram();
		for (int k = 0; k < 9; k++) begin
			checkValue($sformatf("R-type func %02h", fns[k]), memAt(32'h140 + 4 * k),
				expectedAlu(fns[k], a, b, sh));
		end
	endtask

	task automatic immediateOps();
		word_t       a, r;
		logic [15:0] imm;
		a = $random(seed);
		r = $random(seed);
		imm = r[15:0] | 16'h8000; // sign bit set so sign and zero extension differ
		clearMemories();
		dataMem[0] = a;
		placeInstr(iType(opLw, 5'd0, 5'd1, 16'h0000));
		placeInstr(iType(opAddi, 5'd1, 5'd3, imm));
		placeInstr(iType(opAndi, 5'd1, 5'd4, imm));
		placeInstr(iType(opOri, 5'd1, 5'd5, imm));
		placeInstr(iType(opLui, 5'd0, 5'd6, imm));
		for (int k = 0; k < 4; k++) begin
			placeInstr(iType(opSw, 5'd0, regAddr_t'(3 + k), 16'(32'h100 + 4 * k)));
		end
		appendEndMarker();
		runProgram();
		checkValue("addi result", memAt(32'h100), a + {{16{imm[15]}}, imm});
		checkValue("andi result", memAt(32'h104), a & {16'h0, imm});
		checkValue("ori result", memAt(32'h108), a | {16'h0, imm});
		checkValue("lui result", memAt(32'h10c), {imm, 16'h0});
	endtask

	task automatic memoryAccess();
		word_t a, w, c, expected;
		a = $random(seed);
		w = $random(seed);
		c = $random(seed);
		clearMemories();
		dataMem[0] = a;
		dataMem[2] = w;
		dataMem[3] = c;
		placeInstr(iType(opLw, 5'd0, 5'd1, 16'h0000));
		for (int k = 0; k < 4; k++) begin
			placeInstr(iType(opLbu, 5'd0, regAddr_t'(3 + k), 16'(8 + k)));
			placeInstr(iType(opSw, 5'd0, regAddr_t'(3 + k), 16'(32'h100 + 4 * k)));
		end
		for (int k = 0; k < 4; k++) begin
			placeInstr(iType(opSb, 5'd0, 5'd1, 16'(32'h120 + 5 * k))); // lane k of word k
		end
		placeInstr(iType(opAddi, 5'd0, 5'd8, 16'h0004));
		placeInstr(iType(opAddi, 5'd0, 5'd9, 16'h0008));
		placeInstr(rType(5'd8, 5'd10, 5'd9, 5'd0, fnLwn)); // reads 0x00c
		placeInstr(iType(opSw, 5'd0, 5'd10, 16'h0130));
		placeInstr(iType(opAddi, 5'd0, 5'd11, 16'h0130));
		placeInstr(rType(5'd8, 5'd1, 5'd11, 5'd0, fnSwn)); // writes a to 0x134
		appendEndMarker();
		runProgram();
		for (int k = 0; k < 4; k++) begin
			checkValue($sformatf("lbu lane %0d", k), memAt(32'h100 + 4 * k),
				{24'h0, w[8 * k +: 8]});
			expected = fillPattern(32'h120 + 4 * k);
			expected[8 * k +: 8] = a[7:0];
			checkValue($sformatf("sb lane %0d", k), memAt(32'h120 + 4 * k), expected);
		end
		checkValue("lwn data", memAt(32'h130), c);
		checkValue("swn data", memAt(32'h134), a);
	endtask

	task automatic delaySlotFlow();
		word_t executed [9];
		word_t skipped [4];
		executed = '{32'h200, 32'h208, 32'h20c, 32'h210, 32'h218, 32'h21c, 32'h220, 32'h228,
			32'h234};
		skipped = '{32'h204, 32'h214, 32'h224, 32'h238};
		clearMemories();
		placeInstr(iType(opAddi, 5'd0, 5'd1, 16'd5));
		placeInstr(iType(opAddi, 5'd0, 5'd2, 16'd5));
		placeInstr(iType(opAddi, 5'd0, 5'd3, 16'd7));
		placeInstr(iType(opAddi, 5'd0, 5'd20, flagValue[15:0]));
		placeInstr(iType(opBeq, 5'd1, 5'd2, 16'd2)); // slot 4, taken to 7
		storeFlagAt(16'h0200);
		storeFlagAt(16'h0204);
		placeInstr(iType(opBeq, 5'd1, 5'd3, 16'd2)); // slot 7, not taken
		storeFlagAt(16'h0208);
		storeFlagAt(16'h020c);
		placeInstr(iType(opBne, 5'd1, 5'd3, 16'd2)); // slot 10, taken to 13
		storeFlagAt(16'h0210);
		storeFlagAt(16'h0214);
		placeInstr(iType(opBne, 5'd1, 5'd2, 16'd2)); // slot 13, not taken
		storeFlagAt(16'h0218);
		storeFlagAt(16'h021c);
		placeInstr(jType(opJ, slotAddr(22))); // hop over the subroutine
		storeFlagAt(16'h0220);
		storeFlagAt(16'h0224);
		placeInstr(rType(5'd31, 5'd0, 5'd0, 5'd0, fnJr)); // slot 19, subroutine
		storeFlagAt(16'h0234);
		storeFlagAt(16'h0238);
		placeInstr(jType(opJal, slotAddr(19))); // slot 22
		storeFlagAt(16'h0228);
		placeInstr(iType(opSw, 5'd0, 5'd31, 16'h022c)); // return lands here
		appendEndMarker();
		runProgram();
		foreach (executed[k]) begin
			checkValue($sformatf("flag at %03h", executed[k]), memAt(executed[k]), flagValue);
		end
		foreach (skipped[k]) begin
			checkValue($sformatf("skipped at %03h", skipped[k]), memAt(skipped[k]),
				fillPattern(skipped[k]));
		end
		checkValue("jal link", memAt(32'h22c), slotAddr(22) + 32'd8);
	endtask

	initial begin
		seed = 80;
		reset = 1'b1;
		clearMemories();
		for (int i = 0; i < 3; i++) begin
			rTypeArithmetic();
		end
		immediateOps();
		memoryAccess();
		delaySlotFlow();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- flist.f
source/cpuPkg.sv
source/controlUnit.sv
source/aluUnit.sv
source/registerFile.sv
source/loadStoreUnit.sv
source/nextPcUnit.sv
source/cpuCore.sv
testbench/cpuCore_asserts.sv
testbench/tb_cpuCore.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_cpuCore
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
